// ==== hdl/fetchPkg.sv ====
// fetch package with the address and bundle widths, lookup table sizes and control-transfer codes
package fetchPkg;

  localparam int pcWidth     = 32;                    // width of every fetch and target address
  localparam int instWidth   = 32;                    // one instruction word
  localparam int slotCount   = 4;                     // instructions fetched per cycle
  localparam int bundleWidth = instWidth * slotCount; // one cache line holds exactly one bundle
  localparam int bundleBytes = 16;                    // byte stride between sequential bundles
  localparam int instBytes   = instWidth / 8;         // byte stride between slots

  // the bundle offset is dropped from every fetch address, the slot bits sit inside it
  localparam int offsetBits     = $clog2(bundleBytes);
  localparam int instOffsetBits = $clog2(instBytes);
  localparam int slotBits       = $clog2(slotCount);

  // control-transfer type codes as stored in the BTB and carried on the update port
  localparam int brTypeWidth = 2;
  localparam logic [brTypeWidth-1:0] brReturn = 2'd0;
  localparam logic [brTypeWidth-1:0] brCall   = 2'd1;
  localparam logic [brTypeWidth-1:0] brJump   = 2'd2;
  localparam logic [brTypeWidth-1:0] brCond   = 2'd3;

  localparam int btbEntries   = 16; // entries in each slot bank
  localparam int btbIndexBits = $clog2(btbEntries);
  localparam int bpEntries    = 64; // 2-bit counters, indexed by instruction address
  localparam int bpIndexBits  = $clog2(bpEntries);
  localparam int rasDepth     = 8;
  localparam int rasPtrBits   = $clog2(rasDepth);
  localparam int cacheLines   = 16; // one bundle per line
  localparam int cacheIndexBits = $clog2(cacheLines);

endpackage

// ==== hdl/branchTargetBuffer.sv ====
// branch target buffer with one direct-mapped bank per slot, giving hit, type and target per slot
`timescale 1ns/1ps

module branchTargetBuffer import fetchPkg::*; (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [pcWidth-1:0]                     pc_i,
  input  logic                                   updateEn_i,
  input  logic [pcWidth-1:0]                     updatePc_i,
  input  logic [brTypeWidth-1:0]                 updateBrType_i,
  input  logic [pcWidth-1:0]                     updateTargetAddr_i,
  output logic [slotCount-1:0]                   hit_o,
  output logic [slotCount-1:0][brTypeWidth-1:0]  ctrlType_o,
  output logic [slotCount-1:0][pcWidth-1:0]      target_o
);

  localparam int tagWidth = pcWidth - offsetBits - btbIndexBits;

  // valid bits need a reset, the rest of each entry is plain storage
  logic [slotCount-1:0][btbEntries-1:0] entryValid;
  logic [tagWidth-1:0]    tagMem    [slotCount][btbEntries];
  logic [brTypeWidth-1:0] typeMem   [slotCount][btbEntries];
  logic [pcWidth-1:0]     targetMem [slotCount][btbEntries];

  logic [slotBits-1:0]     updBank;  // bank picked by the slot position of the update PC
  logic [btbIndexBits-1:0] updIndex;
  logic [tagWidth-1:0]     updTag;

  assign updBank  = updatePc_i[instOffsetBits +: slotBits];
  assign updIndex = updatePc_i[offsetBits +: btbIndexBits];
  assign updTag   = updatePc_i[pcWidth-1 -: tagWidth];

  // each slot looks up its own instruction address in its own bank
  always_comb begin : slotLookup
    logic [pcWidth-1:0] slotPc;
    for (int k = 0; k < slotCount; k++) begin
      slotPc        = pc_i + pcWidth'(k * instBytes);
      hit_o[k]      = entryValid[k][slotPc[offsetBits +: btbIndexBits]] &&
                      (tagMem[k][slotPc[offsetBits +: btbIndexBits]] ==
                       slotPc[pcWidth-1 -: tagWidth]);
      ctrlType_o[k] = typeMem[k][slotPc[offsetBits +: btbIndexBits]];
      target_o[k]   = targetMem[k][slotPc[offsetBits +: btbIndexBits]];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      entryValid <= '0;
    end else if (updateEn_i) begin
      entryValid[updBank][updIndex] <= 1'b1; // an update always installs, never invalidates
    end
  end

  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      tagMem[updBank][updIndex]    <= updTag;
      typeMem[updBank][updIndex]   <= updateBrType_i;
      targetMem[updBank][updIndex] <= updateTargetAddr_i;
    end
  end

endmodule

// ==== hdl/branchPredictor.sv ====
// bimodal direction predictor built from 2-bit saturating counters, one prediction per slot
`timescale 1ns/1ps

module branchPredictor import fetchPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [pcWidth-1:0]   pc_i,
  input  logic                 updateEn_i,
  input  logic [pcWidth-1:0]   updatePc_i,
  input  logic                 updateDir_i,
  output logic [slotCount-1:0] taken_o
);

  logic [1:0] counter [bpEntries]; // 0 and 1 predict not-taken, 2 and 3 predict taken

  logic [bpIndexBits-1:0] updIndex;
  logic [1:0]             updCount;

  assign updIndex = updatePc_i[instOffsetBits +: bpIndexBits];
  assign updCount = counter[updIndex];

  // the slot number fills the low index bits, the bundle address the rest
  always_comb begin : slotPredict
    logic [pcWidth-1:0] slotPc;
    for (int k = 0; k < slotCount; k++) begin
      slotPc     = pc_i + pcWidth'(k * instBytes);
      taken_o[k] = counter[slotPc[instOffsetBits +: bpIndexBits]][1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < bpEntries; i++) begin
        counter[i] <= 2'd1; // weakly not-taken
      end
    end else if (updateEn_i) begin
      if (updateDir_i && updCount != 2'd3) begin
        counter[updIndex] <= updCount + 2'd1;
      end else if (!updateDir_i && updCount != 2'd0) begin
        counter[updIndex] <= updCount - 2'd1;
      end
    end
  end

endmodule

// ==== hdl/returnAddrStack.sv ====
// return address stack as a circular buffer with push, pop and a combinational top entry
`timescale 1ns/1ps

module returnAddrStack import fetchPkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               push_i,
  input  logic               pop_i,
  input  logic [pcWidth-1:0] pushAddr_i,
  output logic [pcWidth-1:0] top_o
);

  logic [pcWidth-1:0]    stackMem [rasDepth];
  logic [rasPtrBits-1:0] topPtr; // points at the most recent return address
  logic [rasPtrBits-1:0] pushPtr;

  // the pointer wraps, so a deep call chain silently overwrites the oldest entry
  assign pushPtr = topPtr + rasPtrBits'(1);
  assign top_o   = stackMem[topPtr];

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
    end else if (push_i) begin
      topPtr <= pushPtr;
    end else if (pop_i) begin
      topPtr <= topPtr - rasPtrBits'(1); // a pop only moves the pointer, the entry stays
    end
  end

  // only one of push and pop comes from a single taken slot, push wins if both show up
  always_ff @(posedge clk) begin
    if (push_i) begin
      stackMem[pushPtr] <= pushAddr_i;
    end
  end

endmodule

// ==== hdl/instCache.sv ====
// direct-mapped instruction cache holding one bundle per line, with a fill port and miss detection
`timescale 1ns/1ps

module instCache import fetchPkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [pcWidth-1:0]     addr_i,
  input  logic                   wrEnable_i,
  input  logic [pcWidth-1:0]     wrAddr_i,
  input  logic [bundleWidth-1:0] instBlock_i,
  output logic [bundleWidth-1:0] bundle_o,
  output logic                   miss_o,
  output logic [pcWidth-1:0]     missAddr_o
);

  localparam int tagWidth = pcWidth - offsetBits - cacheIndexBits;

  logic [cacheLines-1:0]  lineValid;
  logic [tagWidth-1:0]    tagMem  [cacheLines];
  logic [bundleWidth-1:0] dataMem [cacheLines];

  logic [cacheIndexBits-1:0] rdIndex;
  logic [cacheIndexBits-1:0] wrIndex;

  assign rdIndex = addr_i[offsetBits +: cacheIndexBits];
  assign wrIndex = wrAddr_i[offsetBits +: cacheIndexBits];

  assign bundle_o   = dataMem[rdIndex]; // read is combinational, the data is only used on a hit
  assign miss_o     = !lineValid[rdIndex] || (tagMem[rdIndex] != addr_i[pcWidth-1 -: tagWidth]);
  assign missAddr_o = {addr_i[pcWidth-1:offsetBits], offsetBits'(0)}; // refill asks for the line

  always_ff @(posedge clk) begin
    if (reset) begin
      lineValid <= '0;
    end else if (wrEnable_i) begin
      lineValid[wrIndex] <= 1'b1;
    end
  end

  // a fill replaces the whole line in one cycle
  always_ff @(posedge clk) begin
    if (wrEnable_i) begin
      tagMem[wrIndex]  <= wrAddr_i[pcWidth-1 -: tagWidth];
      dataMem[wrIndex] <= instBlock_i;
    end
  end

endmodule

// ==== hdl/fetchStage1.sv ====
// fetch stage 1 holding the PC, the lookup tables and the next-PC priority select
`timescale 1ns/1ps

module fetchStage1 import fetchPkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall_i,
  input  logic                   recoverFlag_i,
  input  logic [pcWidth-1:0]     recoverPc_i,
  input  logic                   exceptionFlag_i,
  input  logic [pcWidth-1:0]     exceptionPc_i,
  input  logic                   flagRecoverEx_i,
  input  logic [pcWidth-1:0]     targetAddrEx_i,
  input  logic                   flagRecoverId_i,
  input  logic [pcWidth-1:0]     targetAddrId_i,
  input  logic                   updateEn_i,
  input  logic [pcWidth-1:0]     updatePc_i,
  input  logic [pcWidth-1:0]     updateTargetAddr_i,
  input  logic [brTypeWidth-1:0] updateBrType_i,
  input  logic                   updateDir_i,
  input  logic                   wrEnable_i,
  input  logic [pcWidth-1:0]     wrAddr_i,
  input  logic [bundleWidth-1:0] instBlock_i,
  output logic [pcWidth-1:0]     pc_o,
  output logic [bundleWidth-1:0] bundle_o,
  output logic                   hit_o,
  output logic [pcWidth-1:0]     predNextPc_o,
  output logic                   redirect_o,
  output logic                   miss_o,
  output logic [pcWidth-1:0]     missAddr_o
);

  logic [pcWidth-1:0] pc;
  logic               updateBtb;
  logic               updateBp;
  logic               cacheMiss;

  logic [slotCount-1:0]                  btbHit;
  logic [slotCount-1:0][brTypeWidth-1:0] btbType;
  logic [slotCount-1:0][pcWidth-1:0]     btbTarget;
  logic [slotCount-1:0]                  bpTaken;
  logic [pcWidth-1:0]                    rasTop;

  logic                anyTaken;
  logic [slotBits-1:0] takenSlot;
  logic [pcWidth-1:0]  predTarget;
  logic [pcWidth-1:0]  predNextPc;
  logic [pcWidth-1:0]  nextPc;
  logic                idRedirect;
  logic                redirect;
  logic                advance;
  logic                pushRas;
  logic                popRas;
  logic [pcWidth-1:0]  pushAddr;

  // fetch is bundle-aligned everywhere, so the offset bits of any target are dropped
  function automatic logic [pcWidth-1:0] alignBundle(input logic [pcWidth-1:0] addr);
    return {addr[pcWidth-1:offsetBits], offsetBits'(0)};
  endfunction

  assign updateBtb = updateEn_i && (updateBrType_i != brCond || updateDir_i); // taken only
  assign updateBp  = updateEn_i && (updateBrType_i == brCond);

  branchTargetBuffer btb (
    .clk(clk), .reset(reset), .pc_i(pc),
    .updateEn_i(updateBtb), .updatePc_i(updatePc_i), .updateBrType_i(updateBrType_i),
    .updateTargetAddr_i(updateTargetAddr_i),
    .hit_o(btbHit), .ctrlType_o(btbType), .target_o(btbTarget)
  );

  branchPredictor bp (
    .clk(clk), .reset(reset), .pc_i(pc),
    .updateEn_i(updateBp), .updatePc_i(updatePc_i), .updateDir_i(updateDir_i),
    .taken_o(bpTaken)
  );

  returnAddrStack ras (
    .clk(clk), .reset(reset), .push_i(pushRas), .pop_i(popRas),
    .pushAddr_i(pushAddr), .top_o(rasTop)
  );

  instCache icache (
    .clk(clk), .reset(reset), .addr_i(pc),
    .wrEnable_i(wrEnable_i), .wrAddr_i(wrAddr_i), .instBlock_i(instBlock_i),
    .bundle_o(bundle_o), .miss_o(cacheMiss), .missAddr_o(missAddr_o)
  );

  // scan the slots in program order and keep the first one that transfers control
  always_comb begin : firstTakenSlot
    logic found;
    found     = 1'b0;
    takenSlot = '0;
    for (int k = 0; k < slotCount; k++) begin
      if (!found && btbHit[k] && (btbType[k] != brCond || bpTaken[k])) begin
        found     = 1'b1;
        takenSlot = slotBits'(k);
      end
    end
    anyTaken = found;
  end

  always_comb begin
    predTarget = pc + pcWidth'(bundleBytes); // sequential bundle when nothing is taken
    if (anyTaken) begin
      case (btbType[takenSlot])
        brReturn:              predTarget = rasTop;
        brCall, brJump, brCond: predTarget = btbTarget[takenSlot];
      endcase
    end
  end

  assign predNextPc = alignBundle(predTarget);

  // a decode redirect waits while the pipe is stalled, the decoder keeps it raised
  assign idRedirect = flagRecoverId_i && !stall_i;
  assign redirect   = recoverFlag_i || exceptionFlag_i || flagRecoverEx_i || idRedirect;
  assign advance    = !redirect && !stall_i && !cacheMiss;

  always_comb begin
    if (recoverFlag_i) begin
      nextPc = recoverPc_i;
    end else if (exceptionFlag_i) begin
      nextPc = exceptionPc_i;
    end else if (flagRecoverEx_i) begin
      nextPc = targetAddrEx_i; // taken even under stall
    end else if (idRedirect) begin
      nextPc = targetAddrId_i;
    end else begin
      nextPc = predNextPc;
    end
  end

  // the return address of a call is the instruction right after its slot
  assign pushAddr = pc + pcWidth'((int'(takenSlot) + 1) * instBytes);
  assign pushRas  = advance && anyTaken && (btbType[takenSlot] == brCall);
  assign popRas   = advance && anyTaken && (btbType[takenSlot] == brReturn);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect || advance) begin
      pc <= alignBundle(nextPc);
    end
  end

  assign pc_o         = pc;
  assign hit_o        = !cacheMiss;
  assign miss_o       = cacheMiss;
  assign predNextPc_o = predNextPc;
  assign redirect_o   = redirect; // flushes stage 2
endmodule

// ==== hdl/fetchStage2.sv ====
// fetch stage 2 register toward decode, flushed on a redirect and held on stall
`timescale 1ns/1ps

module fetchStage2 import fetchPkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall_i,
  input  logic                   redirect_i,
  input  logic                   hit_i,
  input  logic [pcWidth-1:0]     pc_i,
  input  logic [bundleWidth-1:0] bundle_i,
  input  logic [pcWidth-1:0]     predNextPc_i,
  output logic                   valid_o,
  output logic [pcWidth-1:0]     pc_o,
  output logic [bundleWidth-1:0] bundle_o,
  output logic [pcWidth-1:0]     predNextPc_o
);

  // flush beats stall, a miss loads a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_o <= 1'b0;
    end else if (redirect_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= hit_i;
    end
  end

  // payload only moves when a new entry is accepted
  always_ff @(posedge clk) begin
    if (!stall_i && !redirect_i) begin
      pc_o         <= pc_i;
      bundle_o     <= bundle_i;
      predNextPc_o <= predNextPc_i;
    end
  end

endmodule

// ==== hdl/fetchUnit.sv ====
// fetch unit top joining the PC and lookup stage with the decode-side register
`timescale 1ns/1ps

module fetchUnit import fetchPkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall_i,
  input  logic                   recoverFlag_i,
  input  logic [pcWidth-1:0]     recoverPc_i,
  input  logic                   exceptionFlag_i,
  input  logic [pcWidth-1:0]     exceptionPc_i,
  input  logic                   flagRecoverEx_i,
  input  logic [pcWidth-1:0]     targetAddrEx_i,
  input  logic                   flagRecoverId_i,
  input  logic [pcWidth-1:0]     targetAddrId_i,
  input  logic                   updateEn_i,
  input  logic [pcWidth-1:0]     updatePc_i,
  input  logic [pcWidth-1:0]     updateTargetAddr_i,
  input  logic [brTypeWidth-1:0] updateBrType_i,
  input  logic                   updateDir_i,
  input  logic                   wrEnable_i,
  input  logic [pcWidth-1:0]     wrAddr_i,
  input  logic [bundleWidth-1:0] instBlock_i,
  output logic                   miss_o,
  output logic [pcWidth-1:0]     missAddr_o,
  output logic                   valid_o,
  output logic [pcWidth-1:0]     pc_o,
  output logic [bundleWidth-1:0] bundle_o,
  output logic [pcWidth-1:0]     predNextPc_o
);

  logic [pcWidth-1:0]     s1Pc;
  logic [bundleWidth-1:0] s1Bundle;
  logic                   s1Hit;
  logic [pcWidth-1:0]     s1PredNextPc;
  logic                   s1Redirect;

  fetchStage1 stage1 (
    .clk(clk), .reset(reset), .stall_i(stall_i),
    .recoverFlag_i(recoverFlag_i), .recoverPc_i(recoverPc_i),
    .exceptionFlag_i(exceptionFlag_i), .exceptionPc_i(exceptionPc_i),
    .flagRecoverEx_i(flagRecoverEx_i), .targetAddrEx_i(targetAddrEx_i),
    .flagRecoverId_i(flagRecoverId_i), .targetAddrId_i(targetAddrId_i),
    .updateEn_i(updateEn_i), .updatePc_i(updatePc_i),
    .updateTargetAddr_i(updateTargetAddr_i), .updateBrType_i(updateBrType_i),
    .updateDir_i(updateDir_i),
    .wrEnable_i(wrEnable_i), .wrAddr_i(wrAddr_i), .instBlock_i(instBlock_i),
    .pc_o(s1Pc), .bundle_o(s1Bundle), .hit_o(s1Hit), .predNextPc_o(s1PredNextPc),
    .redirect_o(s1Redirect), .miss_o(miss_o), .missAddr_o(missAddr_o)
  );

  // stage 2 sees the stage 1 lookup one cycle later
  fetchStage2 stage2 (
    .clk(clk), .reset(reset), .stall_i(stall_i), .redirect_i(s1Redirect),
    .hit_i(s1Hit), .pc_i(s1Pc), .bundle_i(s1Bundle), .predNextPc_i(s1PredNextPc),
    .valid_o(valid_o), .pc_o(pc_o), .bundle_o(bundle_o), .predNextPc_o(predNextPc_o)
  );

endmodule

// ==== verif/fetchUnit_asserts.sv ====
// concurrent checks on the fetch unit ports, bound into the top level
`timescale 1ns/1ps

module fetchUnitAsserts import fetchPkg::*; (
  input logic               clk,
  input logic               reset,
  input logic               recoverFlag_i,
  input logic               exceptionFlag_i,
  input logic               flagRecoverEx_i,
  input logic               flagRecoverId_i,
  input logic               miss_i,
  input logic [pcWidth-1:0] missAddr_i,
  input logic               valid_i,
  input logic [pcWidth-1:0] predNextPc_i
);

  int   failCount = 0; // the testbench reads this at the end of the run
  logic anyRedirect;

  // a decode redirect under stall is ignored by the DUT, counting it here only weakens the check
  assign anyRedirect = recoverFlag_i || exceptionFlag_i || flagRecoverEx_i || flagRecoverId_i;

  // stage 2 comes out of reset empty
  validLowAfterReset: assert property (@(posedge clk) reset |=> !valid_i)
    else begin
      failCount++;
      $error("valid_o is set in the cycle after reset");
    end

  // a missing PC holds until a fill or a redirect moves it on
  missAddrStable: assert property (@(posedge clk) disable iff (reset)
    (miss_i && !anyRedirect) |=> (!miss_i || $stable(missAddr_i)))
    else begin
      failCount++;
      $error("missAddr_o changed while the miss persisted without a redirect");
    end

  predNextAligned: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(predNextPc_i) |-> (predNextPc_i[offsetBits-1:0] == '0))
    else begin
      failCount++;
      $error("predNextPc_o is not bundle aligned");
    end

endmodule

bind fetchUnit fetchUnitAsserts fetchUnitAsserts_i (
  .clk(clk), .reset(reset),
  .recoverFlag_i(recoverFlag_i), .exceptionFlag_i(exceptionFlag_i),
  .flagRecoverEx_i(flagRecoverEx_i), .flagRecoverId_i(flagRecoverId_i),
  .miss_i(miss_o), .missAddr_i(missAddr_o), .valid_i(valid_o), .predNextPc_i(predNextPc_o)
);

// ==== verif/fetchUnitTb.sv ====
// fetch unit testbench that steps a scenario table and checks it against a predictor reference model
`timescale 1ns/1ps

module fetchUnitTb import fetchPkg::*; ();

  typedef enum logic [2:0] {actMiss, actFill, actUpdate, actRedirect, actStall, actRun} actionT;

  // one scenario step, flags are recover, exception, execute and decode from the top bit down
  typedef struct packed {
    actionT                 act;
    logic [3:0]             flags;
    logic [pcWidth-1:0]     addr;    // update PC, first fill line, recover target or stall cycles
    logic [pcWidth-1:0]     target;  // update target, fill line count or exception target
    logic [pcWidth-1:0]     tgtEx;
    logic [pcWidth-1:0]     tgtId;
    logic [brTypeWidth-1:0] brType;
    logic                   dir;
    logic [pcWidth-1:0]     expPc;   // pc_o, missAddr_o, or the stage 1 PC after a redirect
    logic [pcWidth-1:0]     expNext;
  } rowT;

  logic                   clk;
  logic                   reset;
  logic                   stall;
  logic                   recoverFlag;
  logic [pcWidth-1:0]     recoverPc;
  logic                   exceptionFlag;
  logic [pcWidth-1:0]     exceptionPc;
  logic                   flagRecoverEx;
  logic [pcWidth-1:0]     targetAddrEx;
  logic                   flagRecoverId;
  logic [pcWidth-1:0]     targetAddrId;
  logic                   updateEn;
  logic [pcWidth-1:0]     updatePc;
  logic [pcWidth-1:0]     updateTargetAddr;
  logic [brTypeWidth-1:0] updateBrType;
  logic                   updateDir;
  logic                   wrEnable;
  logic [pcWidth-1:0]     wrAddr;
  logic [bundleWidth-1:0] instBlock;
  logic                   miss;
  logic [pcWidth-1:0]     missAddr;
  logic                   valid;
  logic [pcWidth-1:0]     pc;
  logic [bundleWidth-1:0] bundle;
  logic [pcWidth-1:0]     predNextPc;

  rowT scenario[$];

  // reference model state, tags are kept as the full instruction address
  bit                     modelBtbValid  [slotCount][btbEntries];
  logic [pcWidth-1:0]     modelBtbPc     [slotCount][btbEntries];
  logic [brTypeWidth-1:0] modelBtbType   [slotCount][btbEntries];
  logic [pcWidth-1:0]     modelBtbTarget [slotCount][btbEntries];
  int                     modelCounter   [bpEntries];
  logic [pcWidth-1:0]     modelStack     [rasDepth];
  int                     modelPtr;
  logic [bundleWidth-1:0] modelLine      [cacheLines];
  logic [pcWidth-1:0]     modelPc; // stage 1 PC as the model sees it

  fetchUnit fetchUnit_i (
    .clk(clk), .reset(reset), .stall_i(stall),
    .recoverFlag_i(recoverFlag), .recoverPc_i(recoverPc),
    .exceptionFlag_i(exceptionFlag), .exceptionPc_i(exceptionPc),
    .flagRecoverEx_i(flagRecoverEx), .targetAddrEx_i(targetAddrEx),
    .flagRecoverId_i(flagRecoverId), .targetAddrId_i(targetAddrId),
    .updateEn_i(updateEn), .updatePc_i(updatePc), .updateTargetAddr_i(updateTargetAddr),
    .updateBrType_i(updateBrType), .updateDir_i(updateDir),
    .wrEnable_i(wrEnable), .wrAddr_i(wrAddr), .instBlock_i(instBlock),
    .miss_o(miss), .missAddr_o(missAddr), .valid_o(valid), .pc_o(pc),
    .bundle_o(bundle), .predNextPc_o(predNextPc)
  );

  always #10 clk = ~clk; // 20 ns period

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic expectEqual(input string name, input logic [bundleWidth-1:0] got,
                             input logic [bundleWidth-1:0] want);
    assert (got === want)
      else reportFailure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want));
  endtask

  task automatic addRow(input actionT act, input logic [3:0] flags,
                        input logic [pcWidth-1:0] addr, input logic [pcWidth-1:0] target,
                        input logic [pcWidth-1:0] tgtEx, input logic [pcWidth-1:0] tgtId,
                        input logic [brTypeWidth-1:0] brType, input logic dir,
                        input logic [pcWidth-1:0] expPc, input logic [pcWidth-1:0] expNext);
    rowT r;
    r = '{act, flags, addr, target, tgtEx, tgtId, brType, dir, expPc, expNext};
    scenario.push_back(r);
  endtask

  // the BTB learns every taken transfer, the counters learn conditional branches only
  task automatic trainModel(input logic [pcWidth-1:0] brPc, input logic [pcWidth-1:0] brTarget,
                            input logic [brTypeWidth-1:0] brType, input logic brTaken);
    int bank;
    int entry;
    int ctr;
    bank  = (brPc / instBytes) % slotCount;
    entry = (brPc / bundleBytes) % btbEntries;
    ctr   = (brPc / instBytes) % bpEntries;
    if (brType != brCond || brTaken) begin
      modelBtbValid[bank][entry]  = 1'b1;
      modelBtbPc[bank][entry]     = brPc;
      modelBtbType[bank][entry]   = brType;
      modelBtbTarget[bank][entry] = brTarget;
    end
    if (brType == brCond && brTaken && modelCounter[ctr] < 3) begin
      modelCounter[ctr]++;
    end else if (brType == brCond && !brTaken && modelCounter[ctr] > 0) begin
      modelCounter[ctr]--;
    end
  endtask

  // first taken slot in program order wins, slot is -1 when the bundle falls through
  function automatic logic [pcWidth-1:0] predictNext(input logic [pcWidth-1:0] fetchPc,
                                                     output int slot);
    logic [pcWidth-1:0] slotPc;
    logic [pcWidth-1:0] dest;
    int                 entry;
    slot = -1;
    dest = fetchPc + bundleBytes;
    for (int k = 0; k < slotCount; k++) begin
      slotPc = fetchPc + k * instBytes;
      entry  = (slotPc / bundleBytes) % btbEntries;
      if (slot < 0 && modelBtbValid[k][entry] && modelBtbPc[k][entry] == slotPc &&
          (modelBtbType[k][entry] != brCond ||
           modelCounter[(slotPc / instBytes) % bpEntries] >= 2)) begin
        slot = k;
        if (modelBtbType[k][entry] == brReturn) begin
          dest = modelStack[modelPtr];
        end else begin
          dest = modelBtbTarget[k][entry];
        end
      end
    end
    return (dest / bundleBytes) * bundleBytes; // low bits are dropped on every target
  endfunction

  // release stall until one bundle lands in stage 2, then hold again
  task automatic stepFetch();
    int cycles;
    cycles = 0;
    stall  = 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      assert (cycles <= 16) else reportFailure("timed out waiting for valid_o after a fetch step");
    end while (!valid);
    stall = 1'b1;
  endtask

  task automatic waitMiss();
    int cycles;
    cycles = 0;
    while (!miss) begin
      @(negedge clk);
      cycles++;
      assert (cycles <= 16) else reportFailure("timed out waiting for miss_o");
    end
  endtask

  task automatic buildScenario();
    //     action       flags    addr   target tgtEx  tgtId  type      dir expPc  expNext
    addRow(actMiss,     4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h000, 'h000);
    addRow(actFill,     4'b0000, 'h000, 16,    'h000, 'h000, 0,        0, 'h000, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h000, 'h010);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h010, 'h020);
    addRow(actUpdate,   4'b0000, 'h028, 'h080, 'h000, 'h000, brJump,   1, 'h000, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h020, 'h080);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h080, 'h090);
    addRow(actUpdate,   4'b0000, 'h094, 'h0C0, 'h000, 'h000, brCond,   0, 'h000, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h090, 'h0A0);
    addRow(actRedirect, 4'b0010, 'h000, 'h000, 'h090, 'h000, 0,        0, 'h090, 'h000);
    addRow(actUpdate,   4'b0000, 'h094, 'h0C0, 'h000, 'h000, brCond,   1, 'h000, 'h000);
    addRow(actUpdate,   4'b0000, 'h094, 'h0C0, 'h000, 'h000, brCond,   1, 'h000, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h090, 'h0C0);
    addRow(actUpdate,   4'b0000, 'h0C4, 'h040, 'h000, 'h000, brCall,   1, 'h000, 'h000);
    addRow(actUpdate,   4'b0000, 'h040, 'h000, 'h000, 'h000, brReturn, 1, 'h000, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h0C0, 'h040);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h040, 'h0C0);
    addRow(actRedirect, 4'b1111, 'h050, 'h060, 'h070, 'h0B0, 0,        0, 'h050, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h050, 'h060);
    addRow(actRedirect, 4'b0011, 'h000, 'h000, 'h0A0, 'h0E0, 0,        0, 'h0A0, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h0A0, 'h0B0);
    addRow(actRedirect, 4'b0001, 'h000, 'h000, 'h000, 'h0E0, 0,        0, 'h0E0, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h0E0, 'h0F0);
    addRow(actStall,    4'b0000, 5,     'h000, 'h000, 'h000, 0,        0, 'h0E0, 'h000);
    addRow(actRun,      4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h0F0, 'h100);
    addRow(actMiss,     4'b0000, 'h000, 'h000, 'h000, 'h000, 0,        0, 'h100, 'h000); // tag miss
  endtask

  initial begin
    rowT                r;
    logic [pcWidth-1:0] next;
    logic [pcWidth-1:0] dest;
    int                 slot;
    int                 entry;
    void'($urandom(18073));
    clk = 1'b0;
    reset = 1'b1;
    stall = 1'b1; // the scenario steps the fetch by releasing stall
    {recoverFlag, exceptionFlag, flagRecoverEx, flagRecoverId} = 4'b0000;
    recoverPc = '0;
    exceptionPc = '0;
    targetAddrEx = '0;
    targetAddrId = '0;
    updateEn = 1'b0;
    updatePc = '0;
    updateTargetAddr = '0;
    updateBrType = '0;
    updateDir = 1'b0;
    wrEnable = 1'b0;
    wrAddr = '0;
    instBlock = '0;
    foreach (modelCounter[i]) modelCounter[i] = 1; // weakly not-taken
    modelPtr = 0;
    modelPc = '0;
    buildScenario();
    repeat (8) @(negedge clk);
    reset = 1'b0;

    foreach (scenario[i]) begin
      r = scenario[i];
      case (r.act)
        actMiss: begin
          waitMiss();
          expectEqual("missAddr_o", missAddr, r.expPc);
        end
        actFill: begin
          for (int n = 0; n < r.target; n++) begin
            wrEnable = 1'b1;
            wrAddr   = r.addr + n * bundleBytes;
            for (int w = 0; w < slotCount; w++) instBlock[w*instWidth +: instWidth] = $urandom;
            modelLine[(wrAddr / bundleBytes) % cacheLines] = instBlock;
            @(negedge clk);
          end
          wrEnable = 1'b0;
          expectEqual("miss_o", miss, 1'b0); // the held PC now hits in a filled line
        end
        actUpdate: begin
          updateEn         = 1'b1;
          updatePc         = r.addr;
          updateTargetAddr = r.target;
          updateBrType     = r.brType;
          updateDir        = r.dir;
          trainModel(r.addr, r.target, r.brType, r.dir);
          @(negedge clk);
          updateEn = 1'b0;
        end
        actRedirect: begin
          stall = 1'b0; // lets a decode redirect through as well
          {recoverFlag, exceptionFlag, flagRecoverEx, flagRecoverId} = r.flags;
          recoverPc    = r.addr;
          exceptionPc  = r.target;
          targetAddrEx = r.tgtEx;
          targetAddrId = r.tgtId;
          if (r.flags[3]) dest = r.addr;
          else if (r.flags[2]) dest = r.target;
          else if (r.flags[1]) dest = r.tgtEx;
          else dest = r.tgtId;
          @(negedge clk);
          {recoverFlag, exceptionFlag, flagRecoverEx, flagRecoverId} = 4'b0000;
          stall = 1'b1;
          expectEqual("valid_o", valid, 1'b0); // flushed bundle
          modelPc = (dest / bundleBytes) * bundleBytes;
          assert (modelPc == r.expPc)
            else reportFailure($sformatf("scenario row %0d expects another redirect winner", i));
        end
        actStall: begin
          for (int n = 0; n < r.addr; n++) begin
            @(negedge clk);
            expectEqual("valid_o", valid, 1'b1);
            expectEqual("pc_o", pc, r.expPc);
            expectEqual("bundle_o", bundle, modelLine[(r.expPc / bundleBytes) % cacheLines]);
          end
        end
        actRun: begin
          stepFetch();
          next = predictNext(modelPc, slot);
          assert (modelPc == r.expPc && next == r.expNext)
            else reportFailure($sformatf("scenario row %0d disagrees with the reference model", i));
          expectEqual("pc_o", pc, modelPc);
          expectEqual("predNextPc_o", predNextPc, next);
          expectEqual("bundle_o", bundle, modelLine[(modelPc / bundleBytes) % cacheLines]);
          // the stack moves on the same edge that advanced the PC
          entry = (modelPc / bundleBytes) % btbEntries;
          if (slot >= 0 && modelBtbType[slot][entry] == brCall) begin
            modelPtr = (modelPtr + 1) % rasDepth;
            modelStack[modelPtr] = modelPc + (slot + 1) * instBytes;
          end else if (slot >= 0 && modelBtbType[slot][entry] == brReturn) begin
            modelPtr = (modelPtr + rasDepth - 1) % rasDepth;
          end
          modelPc = next;
        end
        default: reportFailure($sformatf("scenario row %0d has an unknown action", i));
      endcase
    end

    @(negedge clk);
    if (fetchUnit_i.fetchUnitAsserts_i.failCount != 0) begin
      reportFailure("a bound assertion on the fetch unit ports failed");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
hdl/fetchPkg.sv
hdl/branchTargetBuffer.sv
hdl/branchPredictor.sv
hdl/returnAddrStack.sv
hdl/instCache.sv
hdl/fetchStage1.sv
hdl/fetchStage2.sv
hdl/fetchUnit.sv
verif/fetchUnit_asserts.sv
verif/fetchUnitTb.sv
